/* logic/cmd_deser.sv */
`timescale 1ns/1ps
// command deserializer for the byte-serial command bus
//   collects address low, address high and data bytes after cmd_stb
//   compares the address with the status command under its mask
//   strobes the data byte out as a status control word
module cmd_deser (
    input  logic                    mclk,
    input  logic                    rst,
    input  logic [7:0]              cmd_ad,   // address low, address high, data
    input  logic                    cmd_stb,  // with the first byte
    output status_pkg::status_ctl_t ctl,
    output logic                    ctl_we    // one cycle, two after data byte
);
    import status_pkg::*;

    logic [1:0]  byte_cnt;  // bytes taken, 0 when idle
    logic [23:0] sr_r;      // {data, addr high, addr low} once full
    logic        done_r;    // third byte just shifted in
    logic        addr_hit;  // assembled address matches
    status_ctl_t ctl_r;
    logic        ctl_we_r;

    // only masked bits have to agree
    assign addr_hit = ((sr_r[15:0] ^ CMD_ADDR) & CMD_MASK) == 16'h0000;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= 2'd0;
            done_r   <= 1'b0;
            ctl_we_r <= 1'b0;
        end else begin
            if (cmd_stb)
                byte_cnt <= 2'd1;                  // restart on every strobe
            else if (byte_cnt == 2'd2)
                byte_cnt <= 2'd0;                  // data byte taken, idle
            else if (byte_cnt != 2'd0)
                byte_cnt <= byte_cnt + 2'd1;
            done_r   <= !cmd_stb && (byte_cnt == 2'd2);
            ctl_we_r <= done_r && addr_hit;        // other commands ignored
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt != 2'd0))
            sr_r <= {cmd_ad, sr_r[23:8]};          // newest byte on top
        if (done_r)
            ctl_r <= status_ctl_t'(sr_r[23:16]);   // data byte
    end

    assign ctl    = ctl_r;
    assign ctl_we = ctl_we_r;

endmodule

/* logic/cmd_seq_mux.sv */
`timescale 1ns/1ps
// command sequencer multiplexer top
//   command deserializer programming the status reporting
//   round-robin arbiter from four sequencer channels to one write port
//   status generator reporting the four frame numbers
module cmd_seq_mux (
    input  logic                            mclk,
    input  logic                            rst,
    // command bus
    input  logic [7:0]                      cmd_ad,
    input  logic                            cmd_stb,
    // status bus
    output logic [7:0]                      status_ad,
    output logic                            status_rq,
    input  logic                            status_start,
    // sequencer channels
    input  seq_bus_pkg::frame_num_t         frame_num [seq_bus_pkg::NUM_CHN],
    input  logic [seq_bus_pkg::NUM_CHN-1:0] wr_en,
    input  seq_bus_pkg::seq_wr_t            wr [seq_bus_pkg::NUM_CHN],
    output logic [seq_bus_pkg::NUM_CHN-1:0] ackn,
    // register write port
    output seq_bus_pkg::seq_wr_t            out_wr,
    output logic                            wr_en_out,
    input  logic                            ackn_out
);
    import status_pkg::*;

    status_ctl_t             ctl;      // decoded control byte
    logic                    ctl_we;
    logic [PAYLOAD_BITS-1:0] payload;  // channel 3 on top

    // two low bits reserved, sent as zero
    assign payload = {frame_num[3], frame_num[2], frame_num[1], frame_num[0], 2'b00};

    cmd_deser i_cmd_deser (
        .mclk    (mclk),
        .rst     (rst),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .ctl     (ctl),
        .ctl_we  (ctl_we)
    );

    seq_rr_arbiter i_seq_rr_arbiter (
        .mclk      (mclk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr        (wr),
        .ackn      (ackn),
        .out_wr    (out_wr),
        .wr_en_out (wr_en_out),
        .ackn_out  (ackn_out)
    );

    status_gen i_status_gen (
        .mclk         (mclk),
        .rst          (rst),
        .ctl          (ctl),
        .ctl_we       (ctl_we),
        .payload      (payload),
        .status_ad    (status_ad),
        .status_rq    (status_rq),
        .status_start (status_start)
    );

endmodule

/* logic/seq_bus_pkg.sv */
// sequencer write bus definitions
//   channel count and channel index width
//   register write address and data widths
//   write struct carried on every channel and on the mux output
//   per-channel frame number type
package seq_bus_pkg;

    localparam int NUM_CHN    = 4;                // sensor channels into the mux
    localparam int CHN_BITS   = $clog2(NUM_CHN);  // channel index width
    localparam int WADDR_BITS = 14;               // register write address
    localparam int WDATA_BITS = 32;               // register write data

    // one register write, held by a sequencer until acknowledged
    typedef struct packed {
        logic [WADDR_BITS-1:0] waddr;  // target register
        logic [WDATA_BITS-1:0] wdata;  // value to write
    } seq_wr_t;  // 46 bits

    typedef logic [3:0] frame_num_t;  // frame counter of one channel, wraps

endpackage

/* logic/seq_rr_arbiter.sv */
`timescale 1ns/1ps
// round-robin arbiter for the sequencer write channels
//   hides requests in their acknowledge cycle
//   rotates priority starting after the last served channel
//   registered output write with level valid, one-cycle ackn per channel
//   a new word may replace the one being consumed on the same edge
module seq_rr_arbiter (
    input  logic                            mclk,
    input  logic                            rst,
    input  logic [seq_bus_pkg::NUM_CHN-1:0] wr_en,   // held until ackn
    input  seq_bus_pkg::seq_wr_t            wr [seq_bus_pkg::NUM_CHN],
    output logic [seq_bus_pkg::NUM_CHN-1:0] ackn,    // one-cycle accept
    output seq_bus_pkg::seq_wr_t            out_wr,
    output logic                            wr_en_out,  // level, word valid
    input  logic                            ackn_out    // downstream consumed
);
    import seq_bus_pkg::*;

    logic [NUM_CHN-1:0]  pend;      // real requests this cycle
    logic                any_pend;
    logic [CHN_BITS-1:0] last_r;    // last served channel
    logic [CHN_BITS-1:0] win_idx;   // winner under rotating priority
    logic [NUM_CHN-1:0]  win_oh;    // winner as one-hot
    logic                take;      // load a new word on this edge
    logic                full_r;    // output holds a word
    logic [NUM_CHN-1:0]  ackn_r;
    seq_wr_t             out_wr_r;

    // during its ackn cycle a channel still shows the old enable
    assign pend     = wr_en & ~ackn_r;
    assign any_pend = |pend;
    assign take     = any_pend && (!full_r || ackn_out);  // empty or draining

    // first pending channel after the last one served
    always_comb begin : rr_pick
        logic [CHN_BITS-1:0] idx;
        logic                found;
        win_idx = last_r;
        found   = 1'b0;
        for (int i = 1; i <= NUM_CHN; i++) begin
            idx = last_r + CHN_BITS'(i);  // wraps around
            if (!found && pend[idx]) begin
                win_idx = idx;
                found   = 1'b1;
            end
        end
    end

    assign win_oh = {{(NUM_CHN - 1){1'b0}}, 1'b1} << win_idx;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            full_r <= 1'b0;
            ackn_r <= '0;
            last_r <= CHN_BITS'(NUM_CHN - 1);  // so channel 0 goes first
        end else begin
            ackn_r <= take ? win_oh : '0;      // ackn one cycle after grant
            if (take) begin
                full_r <= 1'b1;
                last_r <= win_idx;
            end else if (ackn_out) begin
                full_r <= 1'b0;                // consumed, nothing new
            end
        end
    end

    // winner's write, held under back-pressure
    always_ff @(posedge mclk) begin
        if (take)
            out_wr_r <= wr[win_idx];
    end

    assign ackn      = ackn_r;
    assign out_wr    = out_wr_r;
    assign wr_en_out = full_r;

endmodule

/* logic/status_gen.sv */
`timescale 1ns/1ps
// status packet generator
//   stores mode and sequence tag from control writes
//   arms on single-mode writes, or on payload change in auto mode
//   request/start handshake with the address byte, then three data bytes
//   a packet armed while another is in flight goes out afterwards
module status_gen (
    input  logic                                mclk,
    input  logic                                rst,
    input  status_pkg::status_ctl_t             ctl,
    input  logic                                ctl_we,
    input  logic [status_pkg::PAYLOAD_BITS-1:0] payload,
    output logic [7:0]                          status_ad,  // address, then data
    output logic                                status_rq,  // held until start
    input  logic                                status_start
);
    import status_pkg::*;

    status_mode_t            mode_r;
    logic [5:0]              seq_r;   // tag for next packets
    logic [PAYLOAD_BITS-1:0] pl_r;    // registered payload
    logic [PAYLOAD_BITS-1:0] pl_rr;   // previous registered payload
    logic [PAYLOAD_BITS-1:0] pl_f;    // frozen when arming
    logic                    pl_chg;
    logic                    arm;     // request a packet
    logic                    pend_r;  // armed, not yet launched
    logic                    launch;  // raise request this edge
    logic                    rq_r;
    logic [1:0]              bcnt;    // data bytes still to send
    logic [23:0]             sh_r;    // packet data, low byte first
    logic [7:0]              ad_r;

    assign pl_chg = pl_r != pl_rr;
    assign arm    = (ctl_we && (ctl.mode == MODE_ONCE || ctl.mode == MODE_ONCE_ALT))
                 || (mode_r == MODE_AUTO && pl_chg);
    assign launch = pend_r && !rq_r && (bcnt == 2'd0);  // bus free

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode_r <= MODE_STOP;
            seq_r  <= 6'd0;
            pl_r   <= '0;
            pl_rr  <= '0;
            pend_r <= 1'b0;
            rq_r   <= 1'b0;
            bcnt   <= 2'd0;
            ad_r   <= 8'h00;
        end else begin
            pl_r  <= payload;
            pl_rr <= pl_r;
            if (ctl_we) begin
                mode_r <= ctl.mode;
                seq_r  <= ctl.seq;
            end
            if (arm)
                pend_r <= 1'b1;  // also keeps one queued behind a launch
            else if (launch)
                pend_r <= 1'b0;
            if (launch) begin
                rq_r <= 1'b1;
                ad_r <= STATUS_ADDR;
            end else if (rq_r && status_start) begin
                rq_r <= 1'b0;    // drops with the start pulse
                ad_r <= sh_r[7:0];
                bcnt <= 2'd2;
            end else if (bcnt != 2'd0) begin
                ad_r <= sh_r[7:0];
                bcnt <= bcnt - 2'd1;
            end else if (!rq_r) begin
                ad_r <= 8'h00;   // idle bus
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (arm)
            pl_f <= pl_r;
        if (launch)
            sh_r <= {pl_f[17:10], pl_f[9:2], seq_r, pl_f[1:0]};
        else if ((rq_r && status_start) || (bcnt != 2'd0))
            sh_r <= {8'h00, sh_r[23:8]};  // next byte down
    end

    assign status_ad = ad_r;
    assign status_rq = rq_r;

endmodule

/* logic/status_pkg.sv */
// command bus and status packet definitions
//   command address and compare mask of this block
//   status register address byte sent first in every packet
//   status mode encoding and the control byte struct
//   status payload width
package status_pkg;

    localparam logic [15:0] CMD_ADDR    = 16'h0702;  // status control command
    localparam logic [15:0] CMD_MASK    = 16'h07ff;  // bits taking part in compare
    localparam logic [7:0]  STATUS_ADDR = 8'h31;     // address byte of status packets

    localparam int PAYLOAD_BITS = 18;  // four frame numbers over two zero bits

    // status reporting modes, low two bits of the control byte
    typedef enum logic [1:0] {
        MODE_STOP     = 2'd0,  // no packets
        MODE_ONCE     = 2'd1,  // one packet now
        MODE_AUTO     = 2'd2,  // packet on each payload change
        MODE_ONCE_ALT = 2'd3   // behaves as single
    } status_mode_t;

    // control byte written over the command bus
    typedef struct packed {
        logic [5:0]   seq;   // tag copied into packets
        status_mode_t mode;  // reporting mode
    } status_ctl_t;

endpackage

/* tb.f */
logic/seq_bus_pkg.sv
logic/status_pkg.sv
logic/cmd_deser.sv
logic/seq_rr_arbiter.sv
logic/status_gen.sv
logic/cmd_seq_mux.sv
tb/cmd_seq_mux_props.sv
tb/tb_cmd_seq_mux.sv

/* tb/cmd_seq_mux_props.sv */
`timescale 1ns/1ps
// handshake assertions for the round-robin arbiter
//   ackn one-hot or idle
//   output word held under back-pressure
//   ackn only towards a requesting channel
//   bound into every seq_rr_arbiter instance
module cmd_seq_mux_props (
    input logic                            mclk,
    input logic                            rst,
    input logic [seq_bus_pkg::NUM_CHN-1:0] wr_en,
    input logic [seq_bus_pkg::NUM_CHN-1:0] ackn,
    input seq_bus_pkg::seq_wr_t            out_wr,
    input logic                            wr_en_out,
    input logic                            ackn_out
);
    int fails = 0;  // failed assertions, summed into the run totals

    a_ackn_onehot: assert property (@(posedge mclk) disable iff (rst)
        $onehot0(ackn))
        else begin
            fails++;
            $error("ackn has more than one channel set");
        end

    a_out_held: assert property (@(posedge mclk) disable iff (rst)
        (wr_en_out && !ackn_out) |=> (wr_en_out && $stable(out_wr)))
        else begin
            fails++;
            $error("output word changed or dropped under back-pressure");
        end

    a_ackn_req: assert property (@(posedge mclk) disable iff (rst)
        (ackn & ~wr_en) == '0)
        else begin
            fails++;
            $error("ackn to a channel without wr_en");
        end

endmodule

bind seq_rr_arbiter cmd_seq_mux_props i_arb_props (
    .mclk      (mclk),
    .rst       (rst),
    .wr_en     (wr_en),
    .ackn      (ackn),
    .out_wr    (out_wr),
    .wr_en_out (wr_en_out),
    .ackn_out  (ackn_out)
);

/* tb/tb_cmd_seq_mux.sv */
`timescale 1ns/1ps
// testbench for the command sequencer multiplexer
//   clock, reset and LFSR random source
//   channel, downstream and status bus models
//   expected write queues per channel and expected status packet
//   arbiter tests, command decode and status packet tests, report
module tb_cmd_seq_mux;
    import seq_bus_pkg::*;
    import status_pkg::*;

    localparam int LIMIT = 3000;  // cycles allowed for any wait

    logic               mclk = 1'b0;
    logic               rst, cmd_stb, status_rq, status_start, wr_en_out, ackn_out;
    logic [7:0]         cmd_ad, status_ad;
    frame_num_t         frame_num [NUM_CHN];
    logic [NUM_CHN-1:0] wr_en, ackn;
    logic [NUM_CHN-1:0] ack_seen = '0;   // ackn seen, channel frees next cycle
    seq_wr_t            wr [NUM_CHN];
    seq_wr_t            out_wr, prev_wr;
    logic [15:0]        lfsr = 16'd97;   // seed
    seq_wr_t            exp_q [NUM_CHN][$];  // issued, not yet at the output
    int                 left [NUM_CHN];  // writes still to issue
    logic [7:0]         exp_pkt [4];     // address byte, then three data bytes
    logic [31:0]        pkt_q [$];       // captured packets, byte 0 lowest
    logic [31:0]        mon_pkt;
    int                 mon_st = 0;      // status monitor step
    int                 errors = 0, tests = 0, failed = 0, last_ch = -1;
    bit                 rand_req = 0, stall_on = 0, rr_chk = 0, prev_stall = 0;

    cmd_seq_mux i_cmd_seq_mux (.*);

    always #10 mclk = ~mclk;  // 20 ns period

    // galois lfsr x^16+x^14+x^13+x^11+1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);  // one step per bit
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic bit chan_idle();
        bit idle;
        idle = (wr_en == '0) && !wr_en_out;
        for (int n = 0; n < NUM_CHN; n++)
            idle = idle && (left[n] == 0) && (exp_q[n].size() == 0);
        return idle;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("** Error @%0t ns: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("%s, at %0t ns", msg, $time);
    endtask

    task automatic check_wr(input seq_wr_t got, input seq_wr_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %h:%h, expected %h:%h", what,
                                   got.waddr, got.wdata, exp.waddr, exp.wdata));
    endtask

    task automatic check_status_byte(input logic [7:0] got, input int idx);
        if (got !== exp_pkt[idx])
            report_error($sformatf("status byte %0d: got %h, expected %h",
                                   idx, got, exp_pkt[idx]));
    endtask

    // channels, downstream ackn and status start
    always @(posedge mclk) begin : drive
        seq_wr_t nw;
        #2;
        for (int n = 0; n < NUM_CHN; n++) begin
            if (ack_seen[n] || !wr_en[n]) begin   // channel free
                ack_seen[n] = 1'b0;
                wr_en[n]    = 1'b0;
                if (!rst && left[n] > 0 && (!rand_req || rand_bits(1) != 0)) begin
                    nw.waddr = WADDR_BITS'(rand_bits(WADDR_BITS));
                    nw.wdata = {2'(n), 30'(rand_bits(30))};  // channel id on top
                    wr[n]    = nw;
                    wr_en[n] = 1'b1;
                    left[n]--;
                    exp_q[n].push_back(nw);
                end
            end
        end
        ackn_out     = wr_en_out && (!stall_on || rand_bits(1) != 0);  // random stalls
        status_start = (mon_st == 1);
        if (mon_st == 1)
            mon_st = 2;
    end

    // mid-cycle sampling of the outputs
    always @(negedge mclk) begin : sample
        int ch;
        if (!rst) begin
            ack_seen = ack_seen | ackn;
            if (prev_stall) begin                  // word must be held
                if (!wr_en_out)
                    report_problem("output valid dropped while stalled");
                check_wr(out_wr, prev_wr, "stalled word");
            end
            prev_stall = wr_en_out && !ackn_out;
            prev_wr    = out_wr;
            if (wr_en_out && ackn_out) begin       // consumed on the coming edge
                ch = int'(out_wr.wdata[31:30]);
                if (exp_q[ch].size() == 0)
                    report_problem($sformatf("extra word from channel %0d", ch));
                else
                    check_wr(out_wr, exp_q[ch].pop_front(), $sformatf("channel %0d", ch));
                if (rr_chk && last_ch >= 0 && ch != (last_ch + 1) % NUM_CHN)
                    report_problem($sformatf("grant to channel %0d after %0d", ch, last_ch));
                last_ch = ch;
            end
            case (mon_st)
                0: if (status_rq) begin
                    mon_pkt[7:0] = status_ad;  // address byte
                    mon_st       = 1;
                end
                2: mon_st = 3;                  // start pulse in flight
                3: begin
                    if (status_rq)
                        report_problem("status_rq still high after start");
                    mon_pkt[15:8] = status_ad;
                    mon_st        = 4;
                end
                4: begin
                    mon_pkt[23:16] = status_ad;
                    mon_st         = 5;
                end
                5: begin
                    mon_pkt[31:24] = status_ad;
                    pkt_q.push_back(mon_pkt);
                    mon_st         = 0;
                end
                default: ;
            endcase
        end
    end

    task automatic next_cycle();
        @(posedge mclk);
        #2;
    endtask

    task automatic run_channels(input logic [NUM_CHN-1:0] active, input int count,
                                input bit rnd, input bit stall, input bit rr);
        int cyc;
        @(posedge mclk);
        #5;  // clear of both model blocks
        rand_req = rnd;
        stall_on = stall;
        rr_chk   = rr;
        last_ch  = -1;
        for (int n = 0; n < NUM_CHN; n++)
            left[n] = active[n] ? count : 0;
        cyc = 0;
        while (!chan_idle() && cyc < LIMIT) begin
            @(posedge mclk);
            cyc++;
        end
        if (!chan_idle()) begin
            report_problem("timeout waiting for all channel writes to be delivered");
            for (int n = 0; n < NUM_CHN; n++) begin
                left[n] = 0;
                exp_q[n].delete();
            end
        end
        rand_req = 0;
        stall_on = 0;
        rr_chk   = 0;
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [7:0] data);
        next_cycle();
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];
        next_cycle();
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        next_cycle();
        cmd_ad  = data;
        next_cycle();
        cmd_ad  = 8'h00;
    endtask

    // packet bytes from the frame numbers now and the tag
    task automatic set_expected(input logic [5:0] seq);
        exp_pkt[0] = STATUS_ADDR;
        exp_pkt[1] = {seq, 2'b00};                  // two reserved payload bits
        exp_pkt[2] = {frame_num[1], frame_num[0]};
        exp_pkt[3] = {frame_num[3], frame_num[2]};
    endtask

    task automatic expect_packet(input string what);
        logic [31:0] pkt;
        int          cyc;
        cyc = 0;
        while (pkt_q.size() == 0 && cyc < LIMIT) begin
            @(posedge mclk);
            cyc++;
        end
        if (pkt_q.size() == 0) begin
            report_problem($sformatf("timeout waiting for a status packet (%s)", what));
        end else begin
            pkt = pkt_q.pop_front();
            for (int i = 0; i < 4; i++)
                check_status_byte(pkt[8*i +: 8], i);
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles) @(posedge mclk);
        if (pkt_q.size() != 0) begin
            report_problem($sformatf("unexpected status packet (%s)", what));
            pkt_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: %0d errors", tests, name, errors - err0);
        end
    endtask

    initial begin : main
        int         err0;
        int         ch;
        logic [5:0] seq;
        rst          = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        ackn_out     = 1'b0;
        wr_en        = '0;
        for (int n = 0; n < NUM_CHN; n++) begin
            wr[n]        = '0;
            frame_num[n] = 4'(n);
            left[n]      = 0;
        end
        repeat (16) @(posedge mclk);
        #2;
        rst = 1'b0;

        err0 = errors;
        run_channels(4'b0010, 10, 0, 0, 0);
        end_test("single channel in order", err0);
        err0 = errors;
        run_channels(4'b1111, 12, 0, 0, 1);
        end_test("round-robin order", err0);
        err0 = errors;
        run_channels(4'b1111, 25, 1, 1, 0);
        end_test("random requests and stalls", err0);

        err0 = errors;
        next_cycle();
        for (int n = 0; n < NUM_CHN; n++)
            frame_num[n] = 4'(rand_bits(4));
        seq = 6'(rand_bits(6));
        send_cmd(16'h0712, {seq, 2'd1});           // bit 4 differs under the mask
        expect_quiet(20, "foreign command address");
        seq = 6'(rand_bits(6));
        set_expected(seq);
        send_cmd(16'h8702, {seq, 2'd1});           // bit 15 outside the mask
        expect_packet("single mode");
        expect_quiet(12, "after single packet");
        end_test("command decode and single packet", err0);

        err0 = errors;
        seq = 6'(rand_bits(6));
        send_cmd(CMD_ADDR, {seq, 2'd2});           // auto mode
        expect_quiet(12, "auto mode without a change");
        for (int k = 0; k < 6; k++) begin
            ch = int'(rand_bits(2));
            next_cycle();
            frame_num[ch] = frame_num[ch] ^ 4'(1 + rand_bits(3));  // never zero
            set_expected(seq);
            expect_packet("auto mode");
            expect_quiet(12, "auto mode after one change");
        end
        send_cmd(CMD_ADDR, {seq, 2'd0});           // stop
        for (int k = 0; k < 3; k++) begin
            next_cycle();
            frame_num[k] = frame_num[k] + 4'd1;
            expect_quiet(12, "stop mode");
        end
        end_test("auto mode and stop", err0);

        errors += i_cmd_seq_mux.i_seq_rr_arbiter.i_arb_props.fails;
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
